/* filelist.f */
+incdir+src
src/lsq_pkg.sv
src/mem_req_if.sv
src/lsq_wr_if.sv
src/lsq_ctrl.sv
src/lsq_entry_ram.sv
src/store_fwd_match.sv
src/dcache_model.sv
src/ldst_unit.sv
tb/tb_ldst_unit.sv

/* run.sh */
#!/usr/bin/env bash
# build the load/store unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ldst_unit -f filelist.f -o sim_ldst_unit \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_ldst_unit)"
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && exit 0 || exit 1

/* src/dcache_model.sv */
// 4 KB data memory model with fixed-latency tagged in-order responses
`timescale 1ns/10ps
`include "lsq_cfg.svh"

module dcache_model import lsq_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  mem_req_if.mem   req,
  output logic     o_rsp_valid,
  output lsq_idx_t o_rsp_id,
  output word_t    o_rsp_rdata
);

  localparam int MEM_AW = $clog2(`DMEM_WORDS);

  word_t             mem_q [`DMEM_WORDS];
  logic [MEM_AW-1:0] widx;                  // word index, addr[11:2]
  logic [`DMEM_LAT-1:0] pipe_valid;
  lsq_idx_t          pipe_id   [`DMEM_LAT];
  word_t             pipe_data [`DMEM_LAT];

  assign widx = req.addr[MEM_AW+1:2];

  // array, word k comes out of reset holding k
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < `DMEM_WORDS; k++) begin
        mem_q[k] <= word_t'(k);
      end
    end else if (req.valid && (req.op == LS_STORE)) begin
      mem_q[widx] <= req.wdata;
    end
  end

  // response strobe shift
  always_ff @(posedge clk) begin
    if (rst) begin
      pipe_valid  <= '0;
      o_rsp_valid <= 1'b0;
    end else begin
      pipe_valid[0] <= req.valid;
      for (int s = 1; s < `DMEM_LAT; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
      o_rsp_valid <= pipe_valid[`DMEM_LAT-1];
    end
  end

  // id and data ride alongside, several may be in flight
  always_ff @(posedge clk) begin
    pipe_id[0]   <= req.id;
    pipe_data[0] <= (req.op == LS_LOAD) ? mem_q[widx] : '0;  // stores return 0
    for (int s = 1; s < `DMEM_LAT; s++) begin
      pipe_id[s]   <= pipe_id[s-1];
      pipe_data[s] <= pipe_data[s-1];
    end
    o_rsp_id    <= pipe_id[`DMEM_LAT-1];
    o_rsp_rdata <= pipe_data[`DMEM_LAT-1];
  end

  // controller's issue register must clear under reset
  a_no_req_in_rst: assert property (@(posedge clk) rst |=> !req.valid)
    else $error("dcache_model: request seen during reset");

endmodule

/* src/ldst_unit.sv */
// load/store unit top: queue control, entry storage, forward search, data memory
`timescale 1ns/10ps
`include "lsq_cfg.svh"

module ldst_unit import lsq_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   i_mem_rd,
  input  logic   i_mem_wr,
  input  word_t  i_addr,
  input  word_t  i_wdata,
  input  tag_t   i_wb,
  input  tag_t   i_z,
  output logic   o_ret_valid,
  output word_t  o_ret_rdata,
  output tag_t   o_ret_wb,
  output tag_t   o_ret_z,
  output ls_op_e o_ret_op,
  output logic   o_full,
  output logic   o_empty
);

  lsq_idx_t              head, tail;
  logic [`LSQ_DEPTH-1:0] live, match;
  logic                  fwd_hit;
  lsq_idx_t              fwd_idx;
  logic                  rsp_valid, rsp_we;
  lsq_idx_t              rsp_id, rsp_idx;
  word_t                 rsp_rdata, rsp_data;

  mem_req_if mem_req ();  // queue to memory
  lsq_wr_if  lsq_wr ();   // allocation into the arrays

  lsq_ctrl ctrl_i (
    .clk, .rst, .i_mem_rd, .i_mem_wr, .i_addr, .i_wdata, .i_wb, .i_z,
    .i_fwd_hit(fwd_hit), .i_rsp_valid(rsp_valid), .i_rsp_id(rsp_id),
    .i_rsp_rdata(rsp_rdata), .o_head(head), .o_tail(tail), .o_live(live),
    .o_rsp_we(rsp_we), .o_rsp_idx(rsp_idx), .o_rsp_data(rsp_data),
    .o_ret_valid, .o_full, .o_empty, .wr(lsq_wr), .req(mem_req)
  );

  lsq_entry_ram ram_i (
    .clk, .rst, .i_addr, .i_fwd_idx(fwd_idx), .i_rsp_we(rsp_we),
    .i_rsp_idx(rsp_idx), .i_rsp_data(rsp_data), .i_head(head),
    .o_match(match), .o_head_rdata(o_ret_rdata), .o_head_wb(o_ret_wb),
    .o_head_z(o_ret_z), .o_head_op(o_ret_op), .wr(lsq_wr)
  );

  store_fwd_match fwd_i (
    .i_match(match), .i_live(live), .i_tail(tail), .o_hit(fwd_hit), .o_idx(fwd_idx)
  );

  dcache_model dmem_i (
    .clk, .rst, .req(mem_req), .o_rsp_valid(rsp_valid), .o_rsp_id(rsp_id),
    .o_rsp_rdata(rsp_rdata)
  );

endmodule

/* src/lsq_cfg.svh */
// queue depth, datapath widths, data memory size and latency macros
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// load/store queue
`define LSQ_DEPTH   15  // entries, slot 15 of the index space unused
`define LSQ_IDX_W   4   // entry index, also the memory request id

// datapath
`define WORD_W      32  // address and data
`define TAG_W       4   // write-back reg tag and z tag

// data memory model
`define DMEM_WORDS  1024  // 4 KB, word index = addr[11:2]
`define DMEM_LAT    2     // cycles from request sample to response

`endif

/* src/lsq_ctrl.sv */
// load/store queue control: pointers, count, entry state, issue, response capture, retire
`timescale 1ns/10ps
`include "lsq_cfg.svh"

module lsq_ctrl import lsq_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_mem_rd,
  input  logic                  i_mem_wr,
  input  word_t                 i_addr,
  input  word_t                 i_wdata,
  input  tag_t                  i_wb,
  input  tag_t                  i_z,
  input  logic                  i_fwd_hit,
  input  logic                  i_rsp_valid,
  input  lsq_idx_t              i_rsp_id,
  input  word_t                 i_rsp_rdata,
  output lsq_idx_t              o_head,
  output lsq_idx_t              o_tail,
  output logic [`LSQ_DEPTH-1:0] o_live,
  output logic                  o_rsp_we,
  output lsq_idx_t              o_rsp_idx,
  output word_t                 o_rsp_data,
  output logic                  o_ret_valid,
  output logic                  o_full,
  output logic                  o_empty,
  lsq_wr_if.ctrl                wr,
  mem_req_if.ctrl               req
);

  lsq_idx_t   head_q, tail_q;
  lsq_idx_t   count_q;                     // entries held, 0..LSQ_DEPTH
  ent_state_e ent_state [`LSQ_DEPTH];
  ls_op_e     ent_op    [`LSQ_DEPTH];
  logic       accept;                      // op allocated this edge
  logic       fwd;                         // load served from the queue
  logic       ret_fire;                    // head retires this edge
  ls_op_e     new_op;

  // circular pointer step, wraps after the last slot
  function automatic lsq_idx_t wrap_inc(input lsq_idx_t p);
    return (p == lsq_idx_t'(`LSQ_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign accept   = i_mem_rd | i_mem_wr;
  assign fwd      = i_mem_rd & i_fwd_hit;  // stores never forward
  assign new_op   = i_mem_wr ? LS_STORE : LS_LOAD;
  assign ret_fire = (ent_state[head_q] == ENT_DONE);

  // allocation goes straight to the entry storage
  always_comb begin
    wr.we      = accept;
    wr.idx     = tail_q;
    wr.addr    = i_addr;
    wr.wdata   = i_wdata;
    wr.wb      = i_wb;
    wr.z       = i_z;
    wr.op      = new_op;
    wr.fwd_hit = fwd;
  end

  // stores still held, candidates for forwarding
  always_comb begin
    for (int k = 0; k < `LSQ_DEPTH; k++) begin
      o_live[k] = (ent_state[k] != ENT_FREE) && (ent_op[k] == LS_STORE);
    end
  end

  // only load responses carry data worth keeping
  assign o_rsp_we   = i_rsp_valid && (ent_op[i_rsp_id] == LS_LOAD);
  assign o_rsp_idx  = i_rsp_id;
  assign o_rsp_data = i_rsp_rdata;

  // pointers, count, slot state
  always_ff @(posedge clk) begin
    if (rst) begin
      head_q      <= '0;
      tail_q      <= '0;
      count_q     <= '0;
      o_ret_valid <= 1'b0;
      for (int k = 0; k < `LSQ_DEPTH; k++) begin
        ent_state[k] <= ENT_FREE;
      end
    end else begin
      o_ret_valid <= ret_fire;  // fields appear with it from the ram
      if (ret_fire) begin
        ent_state[head_q] <= ENT_FREE;
        head_q            <= wrap_inc(head_q);
      end
      if (i_rsp_valid) begin
        ent_state[i_rsp_id] <= ENT_DONE;
      end
      if (accept) begin
        ent_state[tail_q] <= fwd ? ENT_DONE : ENT_WAIT;
        tail_q            <= wrap_inc(tail_q);
      end
      case ({accept, ret_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // none, or one in and one out
      endcase
    end
  end

  // op per slot, written only on allocation
  always_ff @(posedge clk) begin
    if (accept) begin
      ent_op[tail_q] <= new_op;
    end
  end

  // issue register, request goes out the cycle after acceptance
  always_ff @(posedge clk) begin
    if (rst) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= accept & ~fwd;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req.op    <= new_op;
      req.id    <= tail_q;
      req.addr  <= i_addr;
      req.wdata <= i_wdata;
    end
  end

  assign o_head  = head_q;
  assign o_tail  = tail_q;
  assign o_full  = (count_q == lsq_idx_t'(`LSQ_DEPTH));
  assign o_empty = (count_q == '0);

  // core has no back-pressure, it must watch o_full
  a_no_accept_full: assert property (@(posedge clk) disable iff (rst)
    accept |-> !o_full)
    else $error("lsq_ctrl: request accepted while full");

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(i_mem_rd && i_mem_wr))
    else $error("lsq_ctrl: read and write in one cycle");

  // memory only answers slots that actually issued
  a_rsp_to_wait: assert property (@(posedge clk) disable iff (rst)
    i_rsp_valid |-> (ent_state[i_rsp_id] == ENT_WAIT))
    else $error("lsq_ctrl: response for slot %0d not waiting", i_rsp_id);

endmodule

/* src/lsq_entry_ram.sv */
// queue entry arrays with per-entry address compare and registered head read
`timescale 1ns/10ps
`include "lsq_cfg.svh"

module lsq_entry_ram import lsq_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  word_t                 i_addr,      // incoming core address
  input  lsq_idx_t              i_fwd_idx,   // youngest matching store
  input  logic                  i_rsp_we,
  input  lsq_idx_t              i_rsp_idx,
  input  word_t                 i_rsp_data,
  input  lsq_idx_t              i_head,
  output logic [`LSQ_DEPTH-1:0] o_match,
  output word_t                 o_head_rdata,
  output tag_t                  o_head_wb,
  output tag_t                  o_head_z,
  output ls_op_e                o_head_op,
  lsq_wr_if.ram                 wr
);

  word_t  addr_q [`LSQ_DEPTH];
  word_t  data_q [`LSQ_DEPTH];  // store data, or load result
  tag_t   wb_q   [`LSQ_DEPTH];
  tag_t   z_q    [`LSQ_DEPTH];
  ls_op_e op_q   [`LSQ_DEPTH];

  // one comparator per slot, liveness is masked downstream
  always_comb begin
    for (int k = 0; k < `LSQ_DEPTH; k++) begin
      o_match[k] = (addr_q[k] == i_addr);
    end
  end

  always_ff @(posedge clk) begin
    if (wr.we) begin
      addr_q[wr.idx] <= wr.addr;
      wb_q[wr.idx]   <= wr.wb;
      z_q[wr.idx]    <= wr.z;
      op_q[wr.idx]   <= wr.op;
      // forwarded load copies the store's data now
      data_q[wr.idx] <= wr.fwd_hit ? data_q[i_fwd_idx] : wr.wdata;
    end
    if (i_rsp_we) begin
      data_q[i_rsp_idx] <= i_rsp_data;  // load data from memory
    end
  end

  // head snapshot, lines up with the registered retire strobe
  always_ff @(posedge clk) begin
    o_head_rdata <= data_q[i_head];
    o_head_wb    <= wb_q[i_head];
    o_head_z     <= z_q[i_head];
    o_head_op    <= op_q[i_head];
  end

  // a waiting slot is never reallocated before its response lands
  a_alloc_rsp_apart: assert property (@(posedge clk) disable iff (rst)
    (wr.we && i_rsp_we) |-> (wr.idx != i_rsp_idx))
    else $error("lsq_entry_ram: allocation hits slot %0d under response", wr.idx);

endmodule

/* src/lsq_pkg.sv */
// shared types of the load/store unit: widths, op enum, entry-state enum
`include "lsq_cfg.svh"

package lsq_pkg;

  // datapath words
  typedef logic [`WORD_W-1:0] word_t;     // address or data
  typedef logic [`LSQ_IDX_W-1:0] lsq_idx_t;  // queue slot / request id
  typedef logic [`TAG_W-1:0] tag_t;       // wb or z tag

  // memory op carried by each entry and each request
  typedef enum logic {
    LS_LOAD  = 1'b0,
    LS_STORE = 1'b1
  } ls_op_e;

  // life of one queue slot
  typedef enum logic [1:0] {
    ENT_FREE = 2'd0,  // unused
    ENT_WAIT = 2'd1,  // request sent, no response yet
    ENT_DONE = 2'd2   // result known, may retire
  } ent_state_e;

endpackage

/* src/lsq_wr_if.sv */
// entry allocation bundle, queue controller to entry storage
`timescale 1ns/10ps

interface lsq_wr_if import lsq_pkg::*; ();

  logic     we;       // allocate this cycle
  lsq_idx_t idx;      // tail slot
  word_t    addr;
  word_t    wdata;
  tag_t     wb;
  tag_t     z;
  ls_op_e   op;
  logic     fwd_hit;  // load takes data of a queued store

  modport ctrl (
    output we, idx, addr, wdata, wb, z, op, fwd_hit
  );

  modport ram (
    input we, idx, addr, wdata, wb, z, op, fwd_hit
  );

endinterface

/* src/mem_req_if.sv */
// tagged memory request bundle, queue controller to data memory
`timescale 1ns/10ps

interface mem_req_if import lsq_pkg::*; ();

  logic     valid;  // one-cycle strobe, no ready
  ls_op_e   op;
  lsq_idx_t id;     // queue slot that owns the request
  word_t    addr;
  word_t    wdata;  // store data, ignored for loads

  // issuing side, all driven from the issue register
  modport ctrl (
    output valid, op, id, addr, wdata
  );

  // memory side, sampled on each edge with valid high
  modport mem (
    input valid, op, id, addr, wdata
  );

endinterface

/* src/store_fwd_match.sv */
// youngest older matching store search, rotated from the tail
`timescale 1ns/10ps
`include "lsq_cfg.svh"

module store_fwd_match import lsq_pkg::*; (
  input  logic [`LSQ_DEPTH-1:0] i_match,  // address equal per slot
  input  logic [`LSQ_DEPTH-1:0] i_live,   // slot holds a store
  input  lsq_idx_t              i_tail,   // next free slot
  output logic                  o_hit,
  output lsq_idx_t              o_idx
);

  logic [`LSQ_DEPTH-1:0] cand;

  // only queued stores can supply data
  assign cand = i_match & i_live;

  // every live slot is older than the new op, so walk back from tail-1
  // and the nearest hit is the youngest store
  always_comb begin : fwd_search
    int unsigned pos;
    o_hit = 1'b0;
    o_idx = '0;
    // oldest distance first, later hits overwrite
    for (int k = `LSQ_DEPTH; k >= 1; k--) begin
      pos = (int'(i_tail) + `LSQ_DEPTH - k) % `LSQ_DEPTH;
      if (cand[pos]) begin
        o_hit = 1'b1;
        o_idx = lsq_idx_t'(pos);
      end
    end
  end

endmodule

/* tb/tb_ldst_unit.sv */
// testbench for ldst_unit: clock, reset, reference memory, expected retire queue, tests
`timescale 1ns/10ps
`include "lsq_cfg.svh"

module tb_ldst_unit import lsq_pkg::*; ();

  localparam int MEM_AW      = $clog2(`DMEM_WORDS);
  localparam int LONE_LAT    = 5;               // accept edge to o_ret_valid, empty queue
  localparam int TIMEOUT_CYC = 120 * 20 + 600;  // ~120 ops of <=20 cycles, plus margin

  // one expected retirement
  typedef struct packed {
    ls_op_e op;
    word_t  data;
    tag_t   wb;
    tag_t   z;
  } ret_t;

  logic   clk, rst;
  logic   i_mem_rd, i_mem_wr;
  word_t  i_addr, i_wdata;
  tag_t   i_wb, i_z;
  logic   o_ret_valid, o_full, o_empty;
  word_t  o_ret_rdata;
  tag_t   o_ret_wb, o_ret_z;
  ls_op_e o_ret_op;

  word_t  ref_mem [`DMEM_WORDS];  // memory contents in program order
  ret_t   exp_q [$];              // retirements still owed, oldest first
  integer seed;
  int     errors = 0;
  int     n_acc = 0;              // ops accepted by the DUT
  int     n_ret = 0;              // retirements seen
  int     n_ops = 0;
  int     cyc = 0;
  string  cur_test = "none";

  ldst_unit dut_i (
    .clk, .rst, .i_mem_rd, .i_mem_wr, .i_addr, .i_wdata, .i_wb, .i_z,
    .o_ret_valid, .o_ret_rdata, .o_ret_wb, .o_ret_z, .o_ret_op, .o_full, .o_empty
  );

  always #2 clk = ~clk;  // 4 ns period

  task automatic compare_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // drives one op for one cycle, called on a falling edge
  task automatic issue_op(input ls_op_e op, input word_t addr, input word_t wdata);
    ret_t              e;
    logic [MEM_AW-1:0] widx;
    widx = addr[MEM_AW+1:2];  // word index, addr[11:2]
    e.op = op;
    e.wb = tag_t'($random(seed));
    e.z  = tag_t'($random(seed));
    if (op == LS_STORE) begin
      e.data        = wdata;  // stores retire with their own data
      ref_mem[widx] = wdata;
    end else begin
      e.data = ref_mem[widx];  // youngest older store, else memory
    end
    exp_q.push_back(e);
    n_ops++;
    i_mem_rd = (op == LS_LOAD);
    i_mem_wr = (op == LS_STORE);
    i_addr   = addr;
    i_wdata  = wdata;
    i_wb     = e.wb;
    i_z      = e.z;
    @(negedge clk);
    i_mem_rd = 1'b0;
    i_mem_wr = 1'b0;
  endtask

  task automatic wait_not_full();
    while (o_full) @(negedge clk);
  endtask

  // watchdog bounds this loop
  task automatic wait_drain();
    while (!o_empty || exp_q.size() != 0) @(negedge clk);
  endtask

  // lone op into an empty queue, cycles from accepting edge to retirement
  task automatic lone_latency(input ls_op_e op, input word_t addr, input word_t wdata);
    int n;
    issue_op(op, addr, wdata);
    n = 1;  // already one falling edge past the accept
    while (!o_ret_valid && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (!o_ret_valid) begin
      errors++;
      $display("%s: lone operation never retired", cur_test);
    end else if (n - 1 != LONE_LAT) begin
      errors++;
      $display("Fail %s: latency expected %0d actual %0d", cur_test, LONE_LAT, n - 1);
    end
  endtask

  task automatic check_reset_state();
    cur_test = "reset_state";
    compare_word("o_empty", 32'd1, word_t'(o_empty));
    compare_word("o_full", 32'd0, word_t'(o_full));
    compare_word("o_ret_valid", 32'd0, word_t'(o_ret_valid));
  endtask

  task automatic load_untouched();
    cur_test = "load_untouched";
    for (int k = 0; k < 8; k++) begin
      issue_op(LS_LOAD, 32'h200 + 4 * k, 32'h0);  // word index 128+k
    end
    wait_drain();
  endtask

  task automatic store_then_load();
    cur_test = "store_then_load";
    lone_latency(LS_STORE, 32'h300, 32'hcafe_0001);
    wait_drain();
    lone_latency(LS_LOAD, 32'h300, 32'h0);  // store gone, data from memory
    wait_drain();
  endtask

  task automatic forward_store_data();
    cur_test = "forward_store_data";
    issue_op(LS_STORE, 32'h40, 32'h1111_aaaa);
    issue_op(LS_LOAD, 32'h40, 32'h0);
    wait_drain();
    issue_op(LS_STORE, 32'h44, 32'h2222_bbbb);
    issue_op(LS_STORE, 32'h44, 32'h3333_cccc);
    issue_op(LS_LOAD, 32'h44, 32'h0);  // younger store wins
    wait_drain();
  endtask

  // fixed latency keeps the queue shallow, occupancy checked by the monitor
  task automatic fill_and_drain();
    cur_test = "fill_and_drain";
    for (int k = 0; k < `LSQ_DEPTH; k++) begin
      wait_not_full();
      issue_op(LS_LOAD, 32'h400 + 4 * k, 32'h0);
    end
    while (exp_q.size() != 0) @(negedge clk);  // every load retired
    compare_word("o_empty", 32'd1, word_t'(o_empty));
    compare_word("o_full", 32'd0, word_t'(o_full));
  endtask

  task automatic random_mix();
    word_t addr;
    int    gap;
    cur_test = "random_mix";
    for (int k = 0; k < 80; k++) begin
      wait_not_full();
      addr = 32'h100 + 4 * ({$random(seed)} % 8);  // 8 shared words
      if ({$random(seed)} % 2 == 0) begin
        issue_op(LS_STORE, addr, $random(seed));
      end else begin
        issue_op(LS_LOAD, addr, 32'h0);
      end
      gap = {$random(seed)} % 4;
      if (gap >= 2) repeat (gap - 1) @(negedge clk);  // half back to back
    end
    wait_drain();
  endtask

  // retirement compare and occupancy, sampled before the edge updates
  always @(posedge clk) begin : retire_monitor
    ret_t e;
    int   occ;
    if (!rst) begin
      if (o_ret_valid) begin
        n_ret++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: retirement came out with no operation outstanding", cur_test);
        end else begin
          e = exp_q.pop_front();
          compare_word("ret_op", word_t'(e.op), word_t'(o_ret_op));
          compare_word("ret_rdata", e.data, o_ret_rdata);
          compare_word("ret_wb", word_t'(e.wb), word_t'(o_ret_wb));
          compare_word("ret_z", word_t'(e.z), word_t'(o_ret_z));
        end
      end
      occ = n_acc - n_ret;
      compare_word("o_empty", word_t'(occ == 0), word_t'(o_empty));
      compare_word("o_full", word_t'(occ == `LSQ_DEPTH), word_t'(o_full));
      if (i_mem_rd || i_mem_wr) n_acc++;  // allocated on this edge
    end
  end

  always @(posedge clk) begin : watchdog
    cyc++;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout: run still going after %0d cycles", cyc);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    i_mem_rd = 1'b0;
    i_mem_wr = 1'b0;
    i_addr   = '0;
    i_wdata  = '0;
    i_wb     = '0;
    i_z      = '0;
    seed     = 19228;
    for (int k = 0; k < `DMEM_WORDS; k++) begin
      ref_mem[k] = word_t'(k);  // same image as the memory after reset
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    load_untouched();
    store_then_load();
    forward_store_data();
    fill_and_drain();
    random_mix();
    repeat (4) @(negedge clk);
    $display("tb_ldst_unit: %0d errors, %0d ops issued, %0d retirements", errors, n_ops, n_ret);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
